// ==== verilog/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath width
`define RV_XLEN 64

// first fetch address after reset
`define RV_RESET_PC {{(`RV_XLEN-32){1'b0}}, 32'h0000_1000}

// machine external interrupt, interrupt bit on top
`define RV_IRQ_CAUSE {1'b1, {(`RV_XLEN-5){1'b0}}, 4'd11}

// machine csr addresses
`define RV_CSR_MSTATUS  12'h300
`define RV_CSR_MTVEC    12'h305
`define RV_CSR_MSCRATCH 12'h340
`define RV_CSR_MEPC     12'h341
`define RV_CSR_MCAUSE   12'h342

// mstatus fields kept by this core
`define RV_MSTATUS_MIE  3
`define RV_MSTATUS_MPIE 7

`endif

// ==== verilog/rv_isa_pkg.sv ====
`include "rv_consts.svh"

package rv_isa_pkg;

    // major opcodes, encoded as instr[6:0]
    typedef enum logic [6:0] {
        opc_lui      = 7'b0110111,
        opc_auipc    = 7'b0010111,
        opc_jal      = 7'b1101111,
        opc_jalr     = 7'b1100111,
        opc_branch   = 7'b1100011,
        opc_load     = 7'b0000011,
        opc_store    = 7'b0100011,
        opc_op_imm   = 7'b0010011,
        opc_op_imm_w = 7'b0011011,
        opc_op       = 7'b0110011,
        opc_op_w     = 7'b0111011,
        opc_system   = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        ls_byte   = 2'b00,
        ls_half   = 2'b01,
        ls_word   = 2'b10,
        ls_double = 2'b11
    } ls_size_t;

    typedef struct packed {
        opcode_t             opcode;
        alu_op_t             alu_op;
        logic                word;      // W variant, 32-bit result
        logic                imm_sel;   // operand b from immediate
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [2:0]          funct3;
        logic [`RV_XLEN-1:0] imm;
        logic [11:0]         csr_addr;
        logic                legal;
    } decoded_t;

endpackage

// ==== verilog/rv_bus_pkg.sv ====
`include "rv_consts.svh"

package rv_bus_pkg;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  addr;
        logic [`RV_XLEN-1:0]  wdata;
        logic                 write;   // 0 for a load
        rv_isa_pkg::ls_size_t size;
        logic                 uns;     // zero-extend the load
    } bus_req_t;

    // four-phase master states
    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_release
    } lsu_state_t;

endpackage

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decoder (
    input  logic [31:0]          instr_i,
    output rv_isa_pkg::decoded_t dec_o
);

    rv_isa_pkg::opcode_t opc;
    logic [2:0]          f3;
    logic                f7_std;   // funct7 all zero
    logic                f7_alt;   // sub / sra pattern
    logic                reg_form;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm_z;

    assign opc      = rv_isa_pkg::opcode_t'(instr_i[6:0]);
    assign f3       = instr_i[14:12];
    assign f7_std   = instr_i[31:25] == 7'b0000000;
    assign f7_alt   = instr_i[31:25] == 7'b0100000;
    assign reg_form = (opc == rv_isa_pkg::opc_op) || (opc == rv_isa_pkg::opc_op_w);

    assign imm_i = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_z = {{(`RV_XLEN-5){1'b0}}, instr_i[19:15]};   // csr uimm

    always_comb begin
        dec_o          = '0;
        dec_o.opcode   = opc;
        dec_o.rd       = instr_i[11:7];
        dec_o.rs1      = instr_i[19:15];
        dec_o.rs2      = instr_i[24:20];
        dec_o.funct3   = f3;
        dec_o.csr_addr = instr_i[31:20];
        dec_o.word     = (opc == rv_isa_pkg::opc_op_imm_w) || (opc == rv_isa_pkg::opc_op_w);
        dec_o.imm      = imm_i;
        dec_o.imm_sel  = 1'b1;
        dec_o.alu_op   = rv_isa_pkg::alu_add;   // address and auipc adds

        if (reg_form || opc == rv_isa_pkg::opc_op_imm || opc == rv_isa_pkg::opc_op_imm_w) begin
            case (f3)
                3'b000:  dec_o.alu_op = (reg_form && instr_i[30]) ? rv_isa_pkg::alu_sub
                                                                 : rv_isa_pkg::alu_add;
                3'b001:  dec_o.alu_op = rv_isa_pkg::alu_sll;
                3'b010:  dec_o.alu_op = rv_isa_pkg::alu_slt;
                3'b011:  dec_o.alu_op = rv_isa_pkg::alu_sltu;
                3'b100:  dec_o.alu_op = rv_isa_pkg::alu_xor;
                3'b101:  dec_o.alu_op = instr_i[30] ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
                3'b110:  dec_o.alu_op = rv_isa_pkg::alu_or;
                default: dec_o.alu_op = rv_isa_pkg::alu_and;
            endcase
        end

        case (opc)
            rv_isa_pkg::opc_lui, rv_isa_pkg::opc_auipc: begin
                dec_o.imm   = imm_u;
                dec_o.legal = 1'b1;
            end
            rv_isa_pkg::opc_jal: begin
                dec_o.imm   = imm_j;
                dec_o.legal = 1'b1;
            end
            rv_isa_pkg::opc_jalr:   dec_o.legal = f3 == 3'b000;
            rv_isa_pkg::opc_branch: begin
                dec_o.imm     = imm_b;
                dec_o.imm_sel = 1'b0;           // compare rs1 with rs2
                dec_o.legal   = f3[2:1] != 2'b01;
            end
            rv_isa_pkg::opc_load:   dec_o.legal = f3 != 3'b111;   // no ldu
            rv_isa_pkg::opc_store: begin
                dec_o.imm   = imm_s;
                dec_o.legal = !f3[2];
            end
            rv_isa_pkg::opc_op_imm: begin
                // 6-bit shamt leaves only instr[31:26] as funct6
                if (f3 == 3'b001)      dec_o.legal = instr_i[31:26] == 6'b000000;
                else if (f3 == 3'b101) dec_o.legal = instr_i[31:26] == 6'b000000
                                                   || instr_i[31:26] == 6'b010000;
                else                   dec_o.legal = 1'b1;
            end
            rv_isa_pkg::opc_op_imm_w: begin
                dec_o.legal = (f3 == 3'b000) || (f3 == 3'b001 && f7_std)
                              || (f3 == 3'b101 && (f7_std || f7_alt));
            end
            rv_isa_pkg::opc_op: begin
                dec_o.imm_sel = 1'b0;
                dec_o.legal   = f7_std || (f7_alt && (f3 == 3'b000 || f3 == 3'b101));
            end
            rv_isa_pkg::opc_op_w: begin
                dec_o.imm_sel = 1'b0;
                dec_o.legal   = (f3 == 3'b000 && (f7_std || f7_alt)) || (f3 == 3'b001 && f7_std)
                                || (f3 == 3'b101 && (f7_std || f7_alt));
            end
            rv_isa_pkg::opc_system: begin
                dec_o.imm   = imm_z;
                // csr ops, or mret only
                dec_o.legal = (f3 != 3'b000 && f3 != 3'b100) || instr_i == 32'h3020_0073;
            end
            default: dec_o.legal = 1'b0;    // runs as a nop
        endcase
    end

endmodule

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu (
    input  rv_isa_pkg::alu_op_t op_i,
    input  logic                word_i,
    input  logic [`RV_XLEN-1:0] a_i,
    input  logic [`RV_XLEN-1:0] b_i,
    input  logic [2:0]          funct3_i,
    output logic [`RV_XLEN-1:0] result_o,
    output logic                take_branch_o
);

    logic [5:0]          shamt;
    logic [`RV_XLEN-1:0] a_sh;   // shifter input
    logic [`RV_XLEN-1:0] raw;
    logic                eq, lt, ltu;

    assign shamt = word_i ? {1'b0, b_i[4:0]} : b_i[5:0];   // W forms shift by 0..31
    assign eq    = a_i == b_i;
    assign lt    = $signed(a_i) < $signed(b_i);
    assign ltu   = a_i < b_i;

    // word right shifts only see the low half, extended to suit the shift
    always_comb begin
        if (!word_i)                       a_sh = a_i;
        else if (op_i == rv_isa_pkg::alu_sra) a_sh = {{(`RV_XLEN-32){a_i[31]}}, a_i[31:0]};
        else                               a_sh = {{(`RV_XLEN-32){1'b0}}, a_i[31:0]};
    end

    always_comb begin
        case (op_i)
            rv_isa_pkg::alu_add:  raw = a_i + b_i;
            rv_isa_pkg::alu_sub:  raw = a_i - b_i;
            rv_isa_pkg::alu_sll:  raw = a_i << shamt;
            rv_isa_pkg::alu_slt:  raw = {{(`RV_XLEN-1){1'b0}}, lt};
            rv_isa_pkg::alu_sltu: raw = {{(`RV_XLEN-1){1'b0}}, ltu};
            rv_isa_pkg::alu_xor:  raw = a_i ^ b_i;
            rv_isa_pkg::alu_srl:  raw = a_sh >> shamt;
            rv_isa_pkg::alu_sra:  raw = $signed(a_sh) >>> shamt;
            rv_isa_pkg::alu_or:   raw = a_i | b_i;
            default:              raw = a_i & b_i;
        endcase
        result_o = word_i ? {{(`RV_XLEN-32){raw[31]}}, raw[31:0]} : raw;   // sext the word
    end

    // branch condition on the same operands
    always_comb begin
        case (funct3_i)
            3'b000:  take_branch_o = eq;    // beq
            3'b001:  take_branch_o = !eq;   // bne
            3'b100:  take_branch_o = lt;
            3'b101:  take_branch_o = !lt;   // bge
            3'b110:  take_branch_o = ltu;
            3'b111:  take_branch_o = !ltu;  // bgeu
            default: take_branch_o = 1'b0;
        endcase
    end

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                reset,
    input  logic [4:0]          rs1_i,
    input  logic [4:0]          rs2_i,
    input  logic [4:0]          rd_i,
    input  logic                we_i,
    input  logic [`RV_XLEN-1:0] wdata_i,
    output logic [`RV_XLEN-1:0] rdata1_o,
    output logic [`RV_XLEN-1:0] rdata2_o
);

    logic [`RV_XLEN-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wdata_i;
        end
    end

    assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

// ==== verilog/rv_csr_file.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_csr_file (
    input  logic                clk,
    input  logic                reset,
    input  logic [11:0]         csr_addr_i,
    input  logic [2:0]          csr_funct3_i,
    input  logic [`RV_XLEN-1:0] csr_src_i,
    input  logic                csr_en_i,
    output logic [`RV_XLEN-1:0] csr_rdata_o,
    input  logic                irq_take_i,
    input  logic [`RV_XLEN-1:0] irq_pc_i,
    input  logic                mret_i,
    output logic                mie_o,
    output logic [`RV_XLEN-1:0] mtvec_o,
    output logic [`RV_XLEN-1:0] mepc_o
);

    logic                mie_q, mpie_q;   // only live mstatus bits
    logic [`RV_XLEN-1:0] mtvec_q, mscratch_q, mepc_q, mcause_q;
    logic [`RV_XLEN-1:0] mstatus, wdata;
    logic                wr;

    always_comb begin
        mstatus = '0;
        mstatus[`RV_MSTATUS_MIE]  = mie_q;
        mstatus[`RV_MSTATUS_MPIE] = mpie_q;
        case (csr_addr_i)
            `RV_CSR_MSTATUS:  csr_rdata_o = mstatus;
            `RV_CSR_MTVEC:    csr_rdata_o = mtvec_q;
            `RV_CSR_MSCRATCH: csr_rdata_o = mscratch_q;
            `RV_CSR_MEPC:     csr_rdata_o = mepc_q;
            `RV_CSR_MCAUSE:   csr_rdata_o = mcause_q;
            default:          csr_rdata_o = '0;   // unknown csr
        endcase
        case (csr_funct3_i[1:0])
            2'b01:   wdata = csr_src_i;                 // rw
            2'b10:   wdata = csr_rdata_o | csr_src_i;   // rs
            2'b11:   wdata = csr_rdata_o & ~csr_src_i;  // rc
            default: wdata = csr_rdata_o;
        endcase
    end

    // set/clear with zero source is a pure read
    assign wr = csr_en_i && (csr_funct3_i[1:0] == 2'b01 || csr_src_i != '0);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mie_q      <= 1'b1;   // interrupts open out of reset
            mpie_q     <= 1'b0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (irq_take_i) begin
            mepc_q   <= irq_pc_i;
            mcause_q <= `RV_IRQ_CAUSE;
            mpie_q   <= mie_q;
            mie_q    <= 1'b0;
        end else if (mret_i) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (wr) begin
            case (csr_addr_i)
                `RV_CSR_MSTATUS: begin
                    mie_q  <= wdata[`RV_MSTATUS_MIE];
                    mpie_q <= wdata[`RV_MSTATUS_MPIE];
                end
                `RV_CSR_MTVEC:    mtvec_q    <= wdata;
                `RV_CSR_MSCRATCH: mscratch_q <= wdata;
                `RV_CSR_MEPC:     mepc_q     <= wdata;
                `RV_CSR_MCAUSE:   mcause_q   <= wdata;
                default: ;
            endcase
        end
    end

    assign mie_o   = mie_q;
    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

// ==== verilog/rv_lsu.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_lsu (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start_i,
    input  rv_bus_pkg::bus_req_t req_i,
    output logic                 done_o,
    output logic [`RV_XLEN-1:0]  load_data_o,
    output logic                 busy_o,
    output logic                 bus_req_o,
    output rv_bus_pkg::bus_req_t bus_o,
    input  logic                 bus_ack_i,
    input  logic [`RV_XLEN-1:0]  bus_rdata_i
);

    rv_bus_pkg::lsu_state_t state;
    rv_bus_pkg::bus_req_t   req_q;    // held stable for the whole handshake
    logic [`RV_XLEN-1:0]    rdata_q;
    logic                   done_q;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state  <= rv_bus_pkg::st_idle;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                rv_bus_pkg::st_idle:
                    if (start_i) state <= rv_bus_pkg::st_wait_ack;
                rv_bus_pkg::st_wait_ack:
                    if (bus_ack_i) begin
                        state  <= rv_bus_pkg::st_wait_release;
                        done_q <= 1'b1;   // core retires next cycle
                    end
                default:
                    if (!bus_ack_i) state <= rv_bus_pkg::st_idle;   // ack dropped
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (state == rv_bus_pkg::st_idle && start_i) begin
            req_q <= req_i;
            case (req_i.size)   // only the stored lanes go out
                rv_isa_pkg::ls_byte: req_q.wdata <= {{(`RV_XLEN-8){1'b0}}, req_i.wdata[7:0]};
                rv_isa_pkg::ls_half: req_q.wdata <= {{(`RV_XLEN-16){1'b0}}, req_i.wdata[15:0]};
                rv_isa_pkg::ls_word: req_q.wdata <= {{(`RV_XLEN-32){1'b0}}, req_i.wdata[31:0]};
                default:             req_q.wdata <= req_i.wdata;
            endcase
        end
        if (state == rv_bus_pkg::st_wait_ack && bus_ack_i) rdata_q <= bus_rdata_i;
    end

    // load extension by size and unsigned flag
    always_comb begin
        case (req_q.size)
            rv_isa_pkg::ls_byte:
                load_data_o = {{(`RV_XLEN-8){!req_q.uns && rdata_q[7]}}, rdata_q[7:0]};
            rv_isa_pkg::ls_half:
                load_data_o = {{(`RV_XLEN-16){!req_q.uns && rdata_q[15]}}, rdata_q[15:0]};
            rv_isa_pkg::ls_word:
                load_data_o = {{(`RV_XLEN-32){!req_q.uns && rdata_q[31]}}, rdata_q[31:0]};
            default:
                load_data_o = rdata_q;
        endcase
    end

    assign done_o    = done_q;
    assign busy_o    = state != rv_bus_pkg::st_idle;   // includes release phase
    assign bus_req_o = state == rv_bus_pkg::st_wait_ack;
    assign bus_o     = req_q;

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          instr_i,
    output logic [`RV_XLEN-1:0]  pc_o,
    output logic                 bus_req_o,
    output rv_bus_pkg::bus_req_t bus_o,
    input  logic                 bus_ack_i,
    input  logic [`RV_XLEN-1:0]  bus_rdata_i,
    input  logic                 irq_i,
    output logic                 irq_ack_o
);

    logic [`RV_XLEN-1:0]  pc_q, ir_pc_q;   // fetch pc, pc of the execute instruction
    logic [31:0]          ir_q;
    logic                 bubble_q, irq_ack_q;
    rv_isa_pkg::decoded_t dec;
    logic [`RV_XLEN-1:0]  rs1_val, rs2_val, alu_a, alu_b, alu_res;
    logic [`RV_XLEN-1:0]  csr_src, csr_rdata, mtvec, mepc, load_data, wb_data, target;
    logic                 take_branch, mie, lsu_start, lsu_done, lsu_busy;
    logic                 is_load, is_store, is_sys, mem_op, irq_take, stall, ex_go;
    logic                 redirect, wb_we;
    rv_bus_pkg::bus_req_t lsu_req;

    rv_decoder i_rv_decoder (.instr_i(ir_q), .dec_o(dec));

    rv_regfile i_rv_regfile (
        .clk(clk), .reset(reset), .rs1_i(dec.rs1), .rs2_i(dec.rs2), .rd_i(dec.rd),
        .we_i(wb_we), .wdata_i(wb_data), .rdata1_o(rs1_val), .rdata2_o(rs2_val)
    );

    rv_alu i_rv_alu (
        .op_i(dec.alu_op), .word_i(dec.word), .a_i(alu_a), .b_i(alu_b),
        .funct3_i(dec.funct3), .result_o(alu_res), .take_branch_o(take_branch)
    );

    rv_csr_file i_rv_csr_file (
        .clk(clk), .reset(reset), .csr_addr_i(dec.csr_addr), .csr_funct3_i(dec.funct3),
        .csr_src_i(csr_src), .csr_en_i(ex_go && is_sys && dec.funct3 != 3'b000),
        .csr_rdata_o(csr_rdata), .irq_take_i(irq_take), .irq_pc_i(ir_pc_q),
        .mret_i(ex_go && is_sys && dec.funct3 == 3'b000),
        .mie_o(mie), .mtvec_o(mtvec), .mepc_o(mepc)
    );

    rv_lsu i_rv_lsu (
        .clk(clk), .reset(reset), .start_i(lsu_start), .req_i(lsu_req), .done_o(lsu_done),
        .load_data_o(load_data), .busy_o(lsu_busy), .bus_req_o(bus_req_o), .bus_o(bus_o),
        .bus_ack_i(bus_ack_i), .bus_rdata_i(bus_rdata_i)
    );

    assign is_load  = dec.opcode == rv_isa_pkg::opc_load;
    assign is_store = dec.opcode == rv_isa_pkg::opc_store;
    assign is_sys   = dec.opcode == rv_isa_pkg::opc_system;
    assign alu_a    = (dec.opcode == rv_isa_pkg::opc_auipc) ? ir_pc_q : rs1_val;
    assign alu_b    = dec.imm_sel ? dec.imm : rs2_val;
    assign csr_src  = dec.funct3[2] ? dec.imm : rs1_val;   // uimm forms

    assign mem_op    = !bubble_q && dec.legal && (is_load || is_store);
    assign irq_take  = irq_i && mie && !bubble_q && !lsu_busy;   // never mid-transaction
    // hold execute for own access, or while the last one releases
    assign stall     = !bubble_q && !lsu_done && (mem_op || lsu_busy);
    assign lsu_start = mem_op && !lsu_busy && !irq_take;
    assign ex_go     = !bubble_q && !irq_take && !stall && dec.legal;
    assign lsu_req   = '{addr: alu_res, wdata: rs2_val, write: is_store,
                         size: rv_isa_pkg::ls_size_t'(dec.funct3[1:0]), uns: dec.funct3[2]};

    assign redirect = ex_go && (dec.opcode == rv_isa_pkg::opc_jal
                             || dec.opcode == rv_isa_pkg::opc_jalr
                             || (dec.opcode == rv_isa_pkg::opc_branch && take_branch)
                             || (is_sys && dec.funct3 == 3'b000));

    always_comb begin
        case (dec.opcode)
            rv_isa_pkg::opc_jalr:   target = {alu_res[`RV_XLEN-1:1], 1'b0};
            rv_isa_pkg::opc_system: target = mepc;   // mret
            default:                target = ir_pc_q + dec.imm;   // jal, branch
        endcase
        wb_we = ex_go && !is_store && dec.opcode != rv_isa_pkg::opc_branch
                && !(is_sys && dec.funct3 == 3'b000);
        case (dec.opcode)
            rv_isa_pkg::opc_lui:    wb_data = dec.imm;
            rv_isa_pkg::opc_jal,
            rv_isa_pkg::opc_jalr:   wb_data = ir_pc_q + `RV_XLEN'd4;   // link
            rv_isa_pkg::opc_load:   wb_data = load_data;
            rv_isa_pkg::opc_system: wb_data = csr_rdata;   // old csr value
            default:                wb_data = alu_res;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q      <= `RV_RESET_PC;
            ir_pc_q   <= `RV_RESET_PC;
            ir_q      <= 32'h0000_0013;   // addi x0, x0, 0
            bubble_q  <= 1'b0;
            irq_ack_q <= 1'b0;
        end else begin
            irq_ack_q <= irq_take;   // one-cycle pulse
            if (irq_take) begin
                pc_q     <= mtvec;
                ir_q     <= instr_i;   // flushed by the bubble
                ir_pc_q  <= pc_q;
                bubble_q <= 1'b1;
            end else if (!stall) begin
                ir_q     <= instr_i;
                ir_pc_q  <= pc_q;
                bubble_q <= redirect;
                pc_q     <= redirect ? target : pc_q + `RV_XLEN'd4;
            end
        end
    end

    assign pc_o      = pc_q;
    assign irq_ack_o = irq_ack_q;

endmodule

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

    localparam int GOLD_WORDS   = 1024;
    localparam int HANDLER_BASE = 'h100;   // golden index of the code at 0x2000
    localparam int DATA_BASE    = 'h200;
    localparam int REC_BASE     = 'h300;   // record count then addr/data/attr triples
    localparam int DMEM_WORDS   = 64;
    localparam int WAIT_LIMIT   = 200;
    localparam int XFER_LIMIT   = 200;
    localparam logic [63:0] DMEM_ADDR = 64'h3000;

    logic                 clk, reset;
    logic [31:0]          instr;
    logic [`RV_XLEN-1:0]  pc;
    logic                 bus_req, bus_ack, irq, irq_ack, ack_prev;
    rv_bus_pkg::bus_req_t bus;
    logic [`RV_XLEN-1:0]  bus_rdata;
    logic [63:0]          gold [0:GOLD_WORDS-1];
    logic [63:0]          dmem [0:DMEM_WORDS-1];
    logic [31:0]          rng;
    int                   rec_idx, rec_count, irq_raised, irq_pulses, xfers;

    rv_core i_rv_core (
        .clk(clk), .reset(reset), .instr_i(instr), .pc_o(pc),
        .bus_req_o(bus_req), .bus_o(bus), .bus_ack_i(bus_ack), .bus_rdata_i(bus_rdata),
        .irq_i(irq), .irq_ack_o(irq_ack)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction rom with nop for unloaded words
    function automatic logic [31:0] fetch(input logic [63:0] addr);
        logic [63:0] w;
        w = 64'h13;
        if (addr >= 64'h2000 && addr < 64'h2400)
            w = gold[HANDLER_BASE + int'((addr - 64'h2000) >> 2)];
        else if (addr >= `RV_RESET_PC && addr < 64'h1400)
            w = gold[int'((addr - `RV_RESET_PC) >> 2)];
        if ($isunknown(w)) w = 64'h13;
        return w[31:0];
    endfunction

    function automatic logic [63:0] read_mem(input logic [63:0] addr);
        return dmem[int'((addr - DMEM_ADDR) >> 3)] >> (int'(addr[2:0]) * 8);   // lanes to bit 0
    endfunction

    assign instr = fetch(pc);

    task automatic fail(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] exp);
        fail($sformatf("** Error %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_irq_ack(input int pulses, input int raised);
        if (pulses != raised)
            fail($sformatf("** Error irq_ack_o: got 0x%h pulses, expected 0x%h", pulses, raised));
    endtask

    task automatic check_store(input rv_bus_pkg::bus_req_t got, output logic raise_irq);
        logic [63:0] attr;
        int          base;
        base = REC_BASE + 1 + 3 * rec_idx;
        attr = gold[base + 2];
        if (got.addr !== gold[base]) mismatch("bus_o.addr", got.addr, gold[base]);
        if (got.wdata !== gold[base + 1]) mismatch("bus_o.wdata", got.wdata, gold[base + 1]);
        if (got.size !== rv_isa_pkg::ls_size_t'(attr[1:0]))
            mismatch("bus_o.size", 64'(got.size), 64'(attr[1:0]));
        if (attr[9]) check_irq_ack(irq_pulses, irq_raised);   // first store of the handler
        raise_irq = attr[8];
        rec_idx++;
    endtask

    task automatic write_mem(input rv_bus_pkg::bus_req_t req);
        int idx, off, b;
        idx = int'((req.addr - DMEM_ADDR) >> 3);
        off = int'(req.addr[2:0]);
        for (b = 0; b < (1 << int'(req.size)); b++)
            dmem[idx][(off + b) * 8 +: 8] = req.wdata[b * 8 +: 8];
    endtask

    // one full four-phase transfer
    task automatic serve_bus();
        rv_bus_pkg::bus_req_t req;
        int                   n, delay, i;
        logic                 raise_irq;
        n = 0;
        while (!bus_req) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) fail("timeout waiting for a bus request");
        end
        req = bus;
        if (req.addr < DMEM_ADDR || req.addr >= DMEM_ADDR + 64'(DMEM_WORDS * 8))
            fail("bus address outside the data memory");
        if (req.write) begin
            check_store(req, raise_irq);
            write_mem(req);
            if (raise_irq) begin
                irq <= 1'b1;   // store still waiting for ack
                irq_raised++;
            end
        end
        rng   = xorshift(rng);
        delay = int'(rng % 6);
        for (i = 0; i < delay; i++) begin
            @(posedge clk);
            if (!bus_req || bus !== req) fail("request dropped or changed before ack");
        end
        bus_ack   <= 1'b1;
        bus_rdata <= read_mem(req.addr);
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) fail("timeout waiting for the request to drop");
        end while (bus_req);
        // slow ack release, req must stay low meanwhile
        rng   = xorshift(rng);
        delay = int'(rng % 6);
        for (i = 0; i < delay; i++) begin
            @(posedge clk);
            if (bus_req) fail("new request raised while ack was still high");
        end
        bus_ack <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // counts ack pulses and releases irq
    always @(posedge clk) begin
        if (irq_ack) begin
            if (ack_prev) fail("irq_ack_o stayed high for more than one cycle");
            irq_pulses <= irq_pulses + 1;
            irq        <= 1'b0;
        end
        ack_prev <= irq_ack;
    end

    initial begin
        reset      = 1'b0;
        irq        = 1'b0;
        bus_ack    = 1'b0;
        bus_rdata  = '0;
        ack_prev   = 1'b0;
        rng        = 32'ha6e1;
        rec_idx    = 0;
        irq_raised = 0;
        irq_pulses = 0;
        xfers      = 0;
        $readmemh("verification/rv_golden.hex", gold);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = {~(32'h3000 + 32'(i * 8)), 32'h3000 + 32'(i * 8)};   // address fill
            if (!$isunknown(gold[DATA_BASE + i])) dmem[i] = gold[DATA_BASE + i];
        end
        rec_count = int'(gold[REC_BASE]);
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        while (rec_idx < rec_count) begin
            serve_bus();
            xfers++;
            if (xfers > XFER_LIMIT) fail("too many bus transfers before the last record");
        end
        if (irq_raised != 1 || irq_pulses != irq_raised)
            fail("interrupt acknowledge count wrong at the end of the program");
        else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== verification/rv_golden.hex ====
// program words at 0x1000 (@000) and handler at 0x2000 (@100), data dwords at 0x3000 (@200)
// @300 record count, then records: address data attr (attr bits 1:0 size, 8 irq, 9 handler)
@000
00003537 000035B7 10058593 000022B7 30529073 30046073 FFB00093 4010D113
0025B023 03C0D193 0035B423 0030A233 0030B2B3 00458823 005588A3 80000337
FFF3039B 4033543B 003354BB 0075AC23 0285B023 0295B423 40118633 02C59823
00050683 00154703 00251783 00456803 00452883 00053903 00655983 02D5BC23
04E58023 04F5B423 05359823 0505BC23 0715B023 0725B423 00520463 06458823
00521463 064588A3 0030C463 064588A3 0030F463 064588A3 00800AEF 064588A3
0755BC23 010A8B67 064588A3 0965B023 05A00B93 340B9C73 3402ECF3 340BBD73
3400FDF3 34002E73 09858423 099584A3 09A58523 09B585A3 09C58623 0845B823
00700E93 09D5BC23 0000006F
@100
34102F73 34202FF3 0BE5B023 0BF5B423 30200073
@200
F1E2D3C4B5A69788
@300
1B
3100 FFFFFFFFFFFFFFFD 3
3108 000000000000000F 3
3110 0000000000000001 0
3111 0000000000000000 0
3118 000000007FFFFFFF 2
3120 FFFFFFFFFFFF0000 3
3128 0000000000010000 3
3130 0000000000000014 1
3138 FFFFFFFFFFFFFF88 3
3140 0000000000000097 0
3148 FFFFFFFFFFFFB5A6 3
3150 000000000000F1E2 1
3158 00000000F1E2D3C4 3
3160 FFFFFFFFF1E2D3C4 3
3168 F1E2D3C4B5A69788 3
3170 0000000000000001 0
3178 00000000000010BC 3
3180 00000000000010C8 3
3188 0000000000000000 0
3189 000000000000005A 0
318A 000000000000005F 0
318B 0000000000000005 0
318C 0000000000000004 0
3190 0000000000000001 103
31A0 0000000000001100 203
31A8 800000000000000B 3
3198 0000000000000007 3

// ==== flist.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_bus_pkg.sv
verilog/rv_decoder.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_csr_file.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
verification/rv_core_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -Wall -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= rv_core_tb
FLIST      ?= flist.f
BUILD      ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
